// ==== compile.f ====
+incdir+hdl
hdl/corePkg.sv
hdl/execBus.sv
hdl/memBus.sv
hdl/regFile.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memStage.sv
hdl/miniCore.sv
bench/wbMemory.sv
bench/coreTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module coreTb -f compile.f
./obj_dir/VcoreTb > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
grep -q "Result: PASSED" sim.log

// ==== bench/coreTb.sv ====
`timescale 1ns/1ps

module coreTb;

    localparam int RANDOM_COUNT = 400;
    localparam int TOTAL = RANDOM_COUNT + 7;    // plus a final dump of r1..r7
    localparam int DRAIN_LIMIT = 200;
    localparam time WATCH_LIMIT = (8 + RANDOM_COUNT * 8) * 10ns;

    logic clk = 1'b0;
    logic reset;
    logic [31:0] instr;
    logic instrValid;
    logic instrReady;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    logic [31:0] wbAdr;
    logic [31:0] wbDatOut;
    logic [31:0] wbDatIn;
    logic wbAck;
    logic [1:0] waitStates;

    logic [31:0] lfsr = 32'h6a45;
    logic [31:0] prog [TOTAL];
    logic [31:0] modelRegs [8];
    logic [31:0] modelMem [16];
    logic [31:0] expAdr [$];
    logic [31:0] expDat [$];
    int errors = 0;
    int storesSeen = 0;
    bit memSeen = 0;
    logic lastCyc = 1'b0;
    logic lastAck = 1'b0;
    logic lastWe;
    logic [31:0] lastAdr;
    logic [31:0] lastDat;

    always #5 clk = ~clk;

    miniCore miniCore_i (
        .clk(clk),
        .reset(reset),
        .instr(instr),
        .instrValid(instrValid),
        .instrReady(instrReady),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbWe(wbWe),
        .wbAdr(wbAdr),
        .wbDatOut(wbDatOut),
        .wbDatIn(wbDatIn),
        .wbAck(wbAck)
    );

    wbMemory wbMemory_i (
        .clk(clk),
        .reset(reset),
        .cyc(wbCyc),
        .stb(wbStb),
        .we(wbWe),
        .adr(wbAdr),
        .datWrite(wbDatOut),
        .datRead(wbDatIn),
        .ack(wbAck),
        .waitStates(waitStates)
    );

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] rType(input logic [4:0] rs, rt, rd, sh, input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs, rt,
                                          input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] makeInstr();
        logic [3:0] kind;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [15:0] imm;
        logic [15:0] offset;
        kind = 4'(randomBits(4));
        rs = 5'(randomBits(3));
        rt = 5'(randomBits(3));
        rd = 5'(randomBits(3));    // r0 now and then
        imm = 16'(randomBits(16));
        offset = 16'h0100 + {4'(randomBits(4)), 2'b00};
        case (kind)
            0: return rType(rs, rt, rd, 5'd0, 6'h21);
            1: return rType(rs, rt, rd, 5'd0, 6'h23);
            2: return rType(rs, rt, rd, 5'd0, 6'h24);
            3: return rType(rs, rt, rd, 5'd0, 6'h25);
            4: return rType(rs, rt, rd, 5'd0, 6'h26);
            5: return rType(rs, rt, rd, 5'd0, 6'h2a);
            6: return rType(5'd0, rt, rd, 5'(randomBits(5)), 6'h00);
            7: return iType(6'h09, rs, rd, imm);
            8: return iType(6'h0c, rs, rd, imm);
            9: return iType(6'h0d, rs, rd, imm);
            10: return iType(6'h0f, 5'd0, rd, imm);
            11, 12: return iType(6'h23, 5'd0, rd, offset);
            default: return iType(6'h2b, 5'd0, rt, offset);
        endcase
    endfunction

    // sequential reference model
    task automatic modelExecute(input logic [31:0] ins);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] zext;
        logic [31:0] addr;
        logic [31:0] res;
        logic [4:0] dst;
        logic wr;
        a = modelRegs[ins[23:21]];
        b = modelRegs[ins[18:16]];
        sext = {{16{ins[15]}}, ins[15:0]};
        zext = {16'h0, ins[15:0]};
        addr = a + sext;
        res = '0;
        dst = ins[20:16];
        wr = 1'b1;
        case (ins[31:26])
            6'h00: begin
                dst = ins[15:11];
                case (ins[5:0])
                    6'h21: res = a + b;
                    6'h23: res = a - b;
                    6'h24: res = a & b;
                    6'h25: res = a | b;
                    6'h26: res = a ^ b;
                    6'h2a: res = {31'h0, $signed(a) < $signed(b)};
                    default: res = b << ins[10:6];
                endcase
            end
            6'h09: res = a + sext;
            6'h0c: res = a & zext;
            6'h0d: res = a | zext;
            6'h0f: res = {ins[15:0], 16'h0};
            6'h23: res = modelMem[addr[5:2]];
            default: begin
                wr = 1'b0;
                memSeen = 1;
                modelMem[addr[5:2]] = b;
                expAdr.push_back(addr);
                expDat.push_back(b);
            end
        endcase
        if (ins[31:26] == 6'h23) memSeen = 1;
        if (wr && dst != 5'd0) modelRegs[dst[2:0]] = res;
    endtask

    initial begin
        int idx;
        int drain;
        bit accepted;
        instr = '0;
        instrValid = 1'b0;
        waitStates = 2'd0;
        reset = 1'b1;
        for (int i = 0; i < 8; i++) modelRegs[i] = '0;
        for (int i = 0; i < 16; i++) modelMem[i] = 32'h13570000 + i * 32'h00010011;
        for (int i = 0; i < RANDOM_COUNT; i++) prog[i] = makeInstr();
        for (int k = 1; k < 8; k++) begin
            prog[RANDOM_COUNT + k - 1] = iType(6'h2b, 5'd0, k[4:0], 16'h0100 + 16'(k * 4));
        end
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
        idx = 0;
        accepted = 0;
        while (idx < TOTAL) begin
            @(posedge clk);
            #1;
            if (accepted) idx++;
            waitStates = 2'(randomBits(2));
            instr = (idx < TOTAL) ? prog[idx] : '0;
            instrValid = (idx < TOTAL) && (randomBits(2) != 2'd0);
            @(negedge clk);
            accepted = instrValid && instrReady;
            if (accepted) modelExecute(prog[idx]);
        end
        // drain the pipeline
        drain = 0;
        while ((expAdr.size() > 0 || wbCyc) && drain < DRAIN_LIMIT) begin
            @(posedge clk);
            #1 waitStates = 2'(randomBits(2));
            drain++;
        end
        repeat (10) @(posedge clk);
        assert (expAdr.size() == 0 && !wbCyc) else begin
            $display("%0d stores never reached the bus", expAdr.size());
            errors++;
        end
        $display("stores checked %0d, errors %0d", storesSeen, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // outputs settle after the edge, so look at the bus mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            assert (!instrReady && !wbCyc && !wbStb && !wbWe) else begin
                $display("core not idle during reset at %0t", $time);
                errors++;
            end
        end else begin
            assert (!wbCyc || memSeen) else begin
                $display("bus cycle started before any load or store at %0t", $time);
                errors++;
            end
            assert (wbStb == wbCyc) else begin
                $display("mismatch at %0t: wbStb %b with wbCyc %b", $time, wbStb, wbCyc);
                errors++;
            end
            // a waiting access freezes the whole pipeline
            assert (!wbCyc || wbAck || !instrReady) else begin
                $display("instruction input open while a data access waited at %0t", $time);
                errors++;
            end
            if (lastCyc && !lastAck) begin
                assert (wbCyc && wbAdr == lastAdr && wbWe == lastWe && wbDatOut == lastDat)
                else begin
                    $display("mismatch at %0t: request changed before ack", $time);
                    errors++;
                end
            end
            if (wbCyc && wbAck && wbWe) begin
                storesSeen++;
                assert (expAdr.size() > 0) else begin
                    $display("store to %h seen with none expected at %0t", wbAdr, $time);
                    errors++;
                end
                if (expAdr.size() > 0) begin
                    assert (wbAdr == expAdr[0] && wbDatOut == expDat[0]) else begin
                        $display("mismatch at %0t: store %h to %h, expected %h to %h", $time,
                                 wbDatOut, wbAdr, expDat[0], expAdr[0]);
                        errors++;
                    end
                    void'(expAdr.pop_front());
                    void'(expDat.pop_front());
                end
            end
            lastCyc = wbCyc;
            lastAck = wbAck;
            lastWe = wbWe;
            lastAdr = wbAdr;
            lastDat = wbDatOut;
        end
    end

    initial begin
        #(WATCH_LIMIT);
        $display("timeout: the pipeline stopped making progress");
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== bench/wbMemory.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module wbMemory (
    input logic clk,
    input logic reset,
    input logic cyc,
    input logic stb,
    input logic we,
    input logic [`DATA_WIDTH-1:0] adr,
    input logic [`DATA_WIDTH-1:0] datWrite,
    output logic [`DATA_WIDTH-1:0] datRead,
    output logic ack,
    input logic [1:0] waitStates    // sampled when a cycle starts
);

    logic [`DATA_WIDTH-1:0] mem [16];
    logic pending;
    logic [1:0] left;
    logic ackNow;

    initial begin
        for (int i = 0; i < 16; i++) begin
            mem[i] = 32'h13570000 + i * 32'h00010011;
        end
    end

    assign ackNow = pending ? (left == 2'd0) : (waitStates == 2'd0);

    always @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
            pending <= 1'b0;
            left <= 2'd0;
        end else begin
            ack <= 1'b0;
            if (cyc && stb && !ack) begin
                if (ackNow) begin
                    ack <= 1'b1;
                    pending <= 1'b0;
                    datRead <= mem[adr[5:2]];
                    if (we) mem[adr[5:2]] <= datWrite;
                end else if (!pending) begin
                    pending <= 1'b1;
                    left <= waitStates - 2'd1;
                end else begin
                    left <= left - 2'd1;
                end
            end
        end
    end

endmodule

// ==== hdl/miniCore.sv ====
`timescale 1ns/1ps

module miniCore import corePkg::*; (
    input logic clk,
    input logic reset,
    input word_t instr,
    input logic instrValid,
    output logic instrReady,
    output logic wbCyc,
    output logic wbStb,
    output logic wbWe,
    output word_t wbAdr,
    output word_t wbDatOut,
    input word_t wbDatIn,
    input logic wbAck
);

    regAddr_t rsNum;
    regAddr_t rtNum;
    word_t rsData;
    word_t rtData;

    // writeback, also a forwarding source
    logic wbWrite;
    regAddr_t wbDest;
    word_t wbData;

    execBus eBus ();
    memBus mBus ();

    regFile regFile_i (
        .clk(clk),
        .reset(reset),
        .rsNum(rsNum),
        .rtNum(rtNum),
        .rsData(rsData),
        .rtData(rtData),
        .wbWrite(wbWrite),
        .wbDest(wbDest),
        .wbData(wbData)
    );

    decodeStage decodeStage_i (
        .clk(clk),
        .reset(reset),
        .instr(instr),
        .instrValid(instrValid),
        .instrReady(instrReady),
        .rsNum(rsNum),
        .rtNum(rtNum),
        .rsData(rsData),
        .rtData(rtData),
        .freeze(mBus.freeze),
        .eBus(eBus.decoder)
    );

    executeStage executeStage_i (
        .clk(clk),
        .reset(reset),
        .eBus(eBus.executor),
        .mBus(mBus.executor),
        .wbWrite(wbWrite),
        .wbDest(wbDest),
        .wbData(wbData)
    );

    memStage memStage_i (
        .clk(clk),
        .reset(reset),
        .mBus(mBus.memory),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbWe(wbWe),
        .wbAdr(wbAdr),
        .wbDatOut(wbDatOut),
        .wbDatIn(wbDatIn),
        .wbAck(wbAck),
        .wbWrite(wbWrite),
        .wbDest(wbDest),
        .wbData(wbData)
    );

endmodule

// ==== hdl/memStage.sv ====
`timescale 1ns/1ps

module memStage import corePkg::*; (
    input logic clk,
    input logic reset,
    memBus.memory mBus,
    output logic wbCyc,
    output logic wbStb,
    output logic wbWe,
    output word_t wbAdr,
    output word_t wbDatOut,
    input word_t wbDatIn,
    input logic wbAck,
    output logic wbWrite,
    output regAddr_t wbDest,
    output word_t wbData
);

    logic memOp;
    logic busy;    // bus cycle open

    assign memOp = mBus.valid && (mBus.ctrl.memRead || mBus.ctrl.memWrite);

    // whole pipeline waits until the ack cycle
    assign mBus.freeze = memOp && !(busy && wbAck);

    // cycle opens one clock after the access reaches this stage,
    // which also leaves a gap after every ack
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (busy) begin
            if (wbAck) busy <= 1'b0;
        end else if (memOp) begin
            busy <= 1'b1;
        end
    end

    assign wbCyc = busy;
    assign wbStb = busy;
    assign wbWe = busy && mBus.ctrl.memWrite;
    assign wbAdr = mBus.aluResult;    // held by the frozen execute register
    assign wbDatOut = mBus.storeData;

    always_ff @(posedge clk) begin
        if (reset) begin
            wbWrite <= 1'b0;
        end else if (!mBus.freeze) begin
            wbWrite <= mBus.valid && mBus.ctrl.regWrite;
        end
    end

    // load data taken at the ack edge
    always_ff @(posedge clk) begin
        if (!mBus.freeze) begin
            wbDest <= mBus.dest;
            wbData <= mBus.ctrl.memRead ? wbDatIn : mBus.aluResult;
        end
    end

    // strobe only for an access held in this stage
    assert property (@(posedge clk) disable iff (reset) wbStb |-> wbCyc && memOp);

    // request stays put until the slave answers
    assert property (@(posedge clk) disable iff (reset)
        wbCyc && !wbAck |=> wbCyc && wbStb && $stable(wbAdr) && $stable(wbWe)
                            && $stable(wbDatOut));

endmodule

// ==== hdl/executeStage.sv ====
`timescale 1ns/1ps

module executeStage import corePkg::*; (
    input logic clk,
    input logic reset,
    execBus.executor eBus,
    memBus.executor mBus,
    input logic wbWrite,
    input regAddr_t wbDest,
    input word_t wbData
);

    logic memHitA;
    logic memHitB;
    logic wbHitA;
    logic wbHitB;
    word_t fwdA;
    word_t fwdB;
    word_t opA;
    word_t opB;
    word_t result;

    assign eBus.eDest = eBus.dest;
    assign eBus.eLoad = eBus.valid && eBus.ctrl.memRead;

    // memory stage is younger than writeback, so it wins
    assign memHitA = mBus.valid && mBus.ctrl.regWrite && (mBus.dest != '0)
                     && (mBus.dest == eBus.rsNum);
    assign memHitB = mBus.valid && mBus.ctrl.regWrite && (mBus.dest != '0)
                     && (mBus.dest == eBus.rtNum);
    assign wbHitA = wbWrite && (wbDest != '0) && (wbDest == eBus.rsNum);
    assign wbHitB = wbWrite && (wbDest != '0) && (wbDest == eBus.rtNum);

    assign fwdA = memHitA ? mBus.aluResult : (wbHitA ? wbData : eBus.srcA);
    assign fwdB = memHitB ? mBus.aluResult : (wbHitB ? wbData : eBus.srcB);

    assign opA = eBus.ctrl.useShamt ? word_t'(eBus.shamt) : fwdA;
    assign opB = eBus.ctrl.useImm ? eBus.immediate : fwdB;

    always_comb begin
        case (eBus.ctrl.aluOp)
            ALU_ADD: result = opA + opB;
            ALU_SUB: result = opA - opB;
            ALU_AND: result = opA & opB;
            ALU_OR: result = opA | opB;
            ALU_XOR: result = opA ^ opB;
            ALU_SLT: result = word_t'($signed(opA) < $signed(opB));
            ALU_SLL: result = opB << opA[4:0];
            ALU_LUI: result = opB << 16;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mBus.valid <= 1'b0;
        end else if (!mBus.freeze) begin
            mBus.valid <= eBus.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!mBus.freeze) begin
            mBus.ctrl <= eBus.ctrl;
            mBus.dest <= eBus.dest;
            mBus.aluResult <= result;
            mBus.storeData <= fwdB;    // rt after forwarding
        end
    end

    // decode's load-use stall keeps a load result from being forwarded early
    assert property (@(posedge clk) disable iff (reset)
        eBus.valid && mBus.valid && mBus.ctrl.memRead |-> !memHitA && !memHitB);

endmodule

// ==== hdl/decodeStage.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module decodeStage import corePkg::*; (
    input logic clk,
    input logic reset,
    input word_t instr,
    input logic instrValid,
    output logic instrReady,
    output regAddr_t rsNum,
    output regAddr_t rtNum,
    input word_t rsData,
    input word_t rtData,
    input logic freeze,
    execBus.decoder eBus
);

    logic running;    // low until the first cycle after reset
    logic dValid;
    word_t dInstr;
    logic [5:0] opcode;
    logic [5:0] funct;
    ctrl_t ctrl;
    logic known;
    logic immZero;
    logic rdDest;
    word_t immExt;
    logic stall;

    assign opcode = dInstr[31:26];
    assign funct = dInstr[5:0];
    assign rsNum = dInstr[25:21];
    assign rtNum = dInstr[20:16];

    // load in execute feeding this instruction
    assign stall = dValid && eBus.eLoad && ((eBus.eDest == rsNum) || (eBus.eDest == rtNum));
    assign instrReady = running && !stall && !freeze;

    always_ff @(posedge clk) begin
        if (reset) running <= 1'b0;
        else running <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dValid <= 1'b0;
        end else if (!freeze && !stall) begin
            dValid <= instrValid && instrReady;
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid && instrReady) dInstr <= instr;
    end

    always_comb begin
        ctrl = '0;
        known = 1'b1;
        immZero = 1'b0;
        rdDest = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                rdDest = 1'b1;
                ctrl.regWrite = 1'b1;
                case (funct)
                    FN_ADDU: ctrl.aluOp = ALU_ADD;
                    FN_SUBU: ctrl.aluOp = ALU_SUB;
                    FN_AND: ctrl.aluOp = ALU_AND;
                    FN_OR: ctrl.aluOp = ALU_OR;
                    FN_XOR: ctrl.aluOp = ALU_XOR;
                    FN_SLT: ctrl.aluOp = ALU_SLT;
                    FN_SLL: begin
                        ctrl.aluOp = ALU_SLL;
                        ctrl.useShamt = 1'b1;
                    end
                    default: known = 1'b0;
                endcase
            end
            OP_ADDIU, OP_ANDI, OP_ORI, OP_LUI: begin
                ctrl.useImm = 1'b1;
                ctrl.regWrite = 1'b1;
                immZero = (opcode == OP_ANDI) || (opcode == OP_ORI);
                if (opcode == OP_ANDI) ctrl.aluOp = ALU_AND;
                else if (opcode == OP_ORI) ctrl.aluOp = ALU_OR;
                else if (opcode == OP_LUI) ctrl.aluOp = ALU_LUI;
                else ctrl.aluOp = ALU_ADD;
            end
            OP_LW: begin
                ctrl.useImm = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memRead = 1'b1;
            end
            OP_SW: begin
                ctrl.useImm = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            default: known = 1'b0;    // becomes a bubble
        endcase
    end

    assign immExt = immZero ? {{(`DATA_WIDTH-16){1'b0}}, dInstr[15:0]}
                            : {{(`DATA_WIDTH-16){dInstr[15]}}, dInstr[15:0]};

    always_ff @(posedge clk) begin
        if (reset) begin
            eBus.valid <= 1'b0;
        end else if (!freeze) begin
            eBus.valid <= dValid && known && !stall;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            eBus.ctrl <= ctrl;
            eBus.srcA <= rsData;
            eBus.srcB <= rtData;
            eBus.rsNum <= rsNum;
            eBus.rtNum <= rtNum;
            eBus.immediate <= immExt;
            eBus.shamt <= dInstr[10:6];
            eBus.dest <= rdDest ? dInstr[15:11] : dInstr[20:16];
        end
    end

endmodule

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module regFile import corePkg::*; (
    input logic clk,
    input logic reset,
    input regAddr_t rsNum,
    input regAddr_t rtNum,
    output word_t rsData,
    output word_t rtData,
    input logic wbWrite,
    input regAddr_t wbDest,
    input word_t wbData
);

    word_t regs [`REG_COUNT];

    logic writeEn;
    assign writeEn = wbWrite && (wbDest != '0);    // r0 writes dropped

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[wbDest] <= wbData;
        end
    end

    // write-through so decode sees this cycle's writeback
    always_comb begin
        if (writeEn && (wbDest == rsNum)) rsData = wbData;
        else rsData = regs[rsNum];

        if (writeEn && (wbDest == rtNum)) rtData = wbData;
        else rtData = regs[rtNum];
    end

    assert property (@(posedge clk) disable iff (reset)
        wbWrite && (wbDest == '0) && (rsNum == '0) |-> (rsData == '0));

endmodule

// ==== hdl/memBus.sv ====
`timescale 1ns/1ps

interface memBus import corePkg::*; ();

    logic valid;
    ctrl_t ctrl;
    regAddr_t dest;
    word_t aluResult;    // also the data address
    word_t storeData;

    logic freeze;    // data access still waiting

    modport executor (
        output valid, ctrl, dest, aluResult, storeData,
        input freeze
    );

    modport memory (
        input valid, ctrl, dest, aluResult, storeData,
        output freeze
    );

endinterface

// ==== hdl/execBus.sv ====
`timescale 1ns/1ps

interface execBus import corePkg::*; ();

    logic valid;
    ctrl_t ctrl;
    word_t srcA;
    word_t srcB;
    regAddr_t rsNum;
    regAddr_t rtNum;
    word_t immediate;
    logic [4:0] shamt;
    regAddr_t dest;

    // hazard feedback from execute
    regAddr_t eDest;
    logic eLoad;

    modport decoder (
        output valid, ctrl, srcA, srcB, rsNum, rtNum, immediate, shamt, dest,
        input eDest, eLoad
    );

    modport executor (
        input valid, ctrl, srcA, srcB, rsNum, rtNum, immediate, shamt, dest,
        output eDest, eLoad
    );

endinterface

// ==== hdl/corePkg.sv ====
`include "core_settings.svh"

package corePkg;

    typedef logic [`DATA_WIDTH-1:0] word_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] regAddr_t;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ANDI = 6'h0c;
    localparam logic [5:0] OP_ORI = 6'h0d;
    localparam logic [5:0] OP_LUI = 6'h0f;
    localparam logic [5:0] OP_LW = 6'h23;
    localparam logic [5:0] OP_SW = 6'h2b;

    // function field of SPECIAL
    localparam logic [5:0] FN_SLL = 6'h00;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR = 6'h25;
    localparam logic [5:0] FN_XOR = 6'h26;
    localparam logic [5:0] FN_SLT = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,    // signed compare
        ALU_SLL,
        ALU_LUI
    } aluOp_t;

    typedef struct packed {
        aluOp_t aluOp;
        logic useImm;      // operand B is the immediate
        logic useShamt;    // operand A is the shift amount
        logic regWrite;
        logic memRead;
        logic memWrite;
    } ctrl_t;

endpackage

// ==== hdl/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// data word, also the width of a data address
`define DATA_WIDTH 32

// general registers
`define REG_COUNT 32
`define REG_ADDR_WIDTH 5    // log2 of REG_COUNT

`endif
